// ==== alu_settings.svh ====
////////////////////////////////////////////////////////////
// Widths, condition codes and opcodes of the integer
// execution unit. Included by the package and by every
// module that decodes an opcode or a condition.
////////////////////////////////////////////////////////////
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

`define ALU_DATA_W  64
`define ALU_FLAGS_W 6
`define ALU_COND_W  4
`define ALU_OP_W    8

// condition codes, c is a borrow after subtract
`define COND_Z   4'd0
`define COND_NZ  4'd1
`define COND_S   4'd2
`define COND_NS  4'd3
`define COND_UGT 4'd4
`define COND_ULE 4'd5
`define COND_UGE 4'd6
`define COND_ULT 4'd7
`define COND_SGT 4'd8
`define COND_SLE 4'd9
`define COND_SGE 4'd10
`define COND_SLT 4'd11
`define COND_O   4'd12
`define COND_NO  4'd13
`define COND_P   4'd14
`define COND_NP  4'd15

`define OP_ADD8     8'h00
`define OP_ADD16    8'h01
`define OP_ADD32    8'h02
`define OP_ADD64    8'h03
`define OP_SUB8     8'h04
`define OP_SUB16    8'h05
`define OP_SUB32    8'h06
`define OP_SUB64    8'h07
`define OP_AND32    8'h10
`define OP_AND64    8'h11
`define OP_OR32     8'h12
`define OP_OR64     8'h13
`define OP_XOR32    8'h14
`define OP_XOR64    8'h15
`define OP_XNOR32   8'h16
`define OP_XNOR64   8'h17
`define OP_MOV32    8'h20
`define OP_MOV64    8'h21
`define OP_ZXT8_64  8'h28
`define OP_ZXT16_64 8'h29
`define OP_SXT8_64  8'h2c
`define OP_SXT16_64 8'h2d
`define OP_SXT32_64 8'h2e
`define OP_CMOV64   8'h30
`define OP_CSET     8'h31

`endif

// ==== alu_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the execution unit: operand vectors,
// the flag word and the issue, adder and return packets.
// Referenced by scoped names from the RTL and testbench.
////////////////////////////////////////////////////////////
`include "alu_settings.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0] data_t;
  typedef logic [`ALU_OP_W-1:0]   op_t;
  typedef logic [`ALU_COND_W-1:0] cond_t;

  // same bit order as the architectural flag word
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    logic   valid;
    logic   thread;
    op_t    op;
    cond_t  cond;
    data_t  a;
    data_t  b;
    flags_t flags_in;
  } issue_t;

  typedef struct packed {
    data_t sum;
    logic  c4;  // into bit 4
    logic  c8;
    logic  c16;
    logic  c32;
    logic  c64;
  } adder_out_t;

  typedef struct packed {
    logic   valid;
    logic   thread;
    logic   sets_flags;
    flags_t flags;
    data_t  result;
  } ret_t;

endpackage

// ==== cond_eval.sv ====
////////////////////////////////////////////////////////////
// Condition evaluator. Maps a flag word and a 4-bit
// condition code to a taken bit for cmov and cset.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_settings.svh"

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            taken
);

  logic s_ne_o;

  assign s_ne_o = flags.s ^ flags.o;

  always_comb
  begin
    case (cond)
      `COND_Z:   taken = flags.z;
      `COND_NZ:  taken = ~flags.z;
      `COND_S:   taken = flags.s;
      `COND_NS:  taken = ~flags.s;
      `COND_UGT: taken = ~flags.c & ~flags.z; // no borrow, nonzero
      `COND_ULE: taken = flags.c | flags.z;
      `COND_UGE: taken = ~flags.c;
      `COND_ULT: taken = flags.c;
      `COND_SGT: taken = ~s_ne_o & ~flags.z;
      `COND_SLE: taken = s_ne_o | flags.z;
      `COND_SGE: taken = ~s_ne_o;
      `COND_SLT: taken = s_ne_o;
      `COND_O:   taken = flags.o;
      `COND_NO:  taken = ~flags.o;
      `COND_P:   taken = flags.p;
      `COND_NP:  taken = ~flags.p;
      default:   taken = 1'b0;
    endcase
  end

endmodule

// ==== int_adder.sv ====
////////////////////////////////////////////////////////////
// 64-bit add/subtract with carry taps at 4, 8, 16, 32 and
// 64 bits. For subtract the taps read as borrows; the
// writeback picks the tap that matches the op width.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_settings.svh"

module int_adder (
  input  alu_pkg::data_t      a,
  input  alu_pkg::data_t      b,
  input  alu_pkg::op_t        op,
  output alu_pkg::adder_out_t out
);

  logic                  is_sub;
  alu_pkg::data_t        b_x;
  logic [`ALU_DATA_W:0]  full;
  logic [`ALU_DATA_W:0]  cin;

  assign is_sub = op inside {`OP_SUB8, `OP_SUB16, `OP_SUB32, `OP_SUB64};

  // a - b as a + ~b + 1
  assign b_x  = is_sub ? ~b : b;
  assign full = {1'b0, a} + {1'b0, b_x} + {{`ALU_DATA_W{1'b0}}, is_sub};

  // carry into each bit position, top bit is the carry out
  assign cin = full ^ {1'b0, a} ^ {1'b0, b_x};

  assign out.sum = full[`ALU_DATA_W-1:0];
  assign out.c4  = cin[4] ^ is_sub;
  assign out.c8  = cin[8] ^ is_sub;
  assign out.c16 = cin[16] ^ is_sub;
  assign out.c32 = cin[32] ^ is_sub;
  assign out.c64 = cin[`ALU_DATA_W] ^ is_sub;

endmodule

// ==== logic_move_unit.sv ====
////////////////////////////////////////////////////////////
// Bitwise logic, moves, zero/sign extension, cmov and
// cset. Combinational; is_logic tells the writeback that
// the op sets s, z and p and clears c, o and a.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_settings.svh"

module logic_move_unit (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  alu_pkg::op_t   op,
  input  logic           taken,
  output alu_pkg::data_t result,
  output logic           is_logic
);

  localparam int HALF = `ALU_DATA_W / 2;

  alu_pkg::data_t and_v;
  alu_pkg::data_t or_v;
  alu_pkg::data_t xor_v;

  assign and_v = a & b;
  assign or_v  = a | b;
  assign xor_v = a ^ b;

  assign is_logic = op inside {`OP_AND32, `OP_AND64, `OP_OR32, `OP_OR64,
                               `OP_XOR32, `OP_XOR64, `OP_XNOR32, `OP_XNOR64};

  always_comb
  begin
    case (op)
      // 32-bit forms clear the upper half
      `OP_AND32:   result = {{HALF{1'b0}}, and_v[HALF-1:0]};
      `OP_AND64:   result = and_v;
      `OP_OR32:    result = {{HALF{1'b0}}, or_v[HALF-1:0]};
      `OP_OR64:    result = or_v;
      `OP_XOR32:   result = {{HALF{1'b0}}, xor_v[HALF-1:0]};
      `OP_XOR64:   result = xor_v;
      `OP_XNOR32:  result = {{HALF{1'b0}}, ~xor_v[HALF-1:0]};
      `OP_XNOR64:  result = ~xor_v;
      `OP_MOV32:   result = {{HALF{1'b0}}, b[HALF-1:0]};
      `OP_MOV64:   result = b;
      `OP_ZXT8_64:
        result = {{(`ALU_DATA_W-8){1'b0}}, b[7:0]};
      `OP_ZXT16_64:
        result = {{(`ALU_DATA_W-16){1'b0}}, b[15:0]};
      `OP_SXT8_64:
        result = {{(`ALU_DATA_W-8){b[7]}}, b[7:0]};
      `OP_SXT16_64:
        result = {{(`ALU_DATA_W-16){b[15]}}, b[15:0]};
      `OP_SXT32_64:
        result = {{HALF{b[HALF-1]}}, b[HALF-1:0]};
      `OP_CMOV64:  result = taken ? b : a; // a is the old destination
      `OP_CSET:    result = {{(`ALU_DATA_W-1){1'b0}}, taken};
      default:     result = '0;
    endcase
  end

endmodule

// ==== flag_writeback.sv ====
////////////////////////////////////////////////////////////
// Result select, flag generation at the op width, thread
// inhibit and the return register. An issue sampled at one
// edge shows on ret after that edge for one cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_settings.svh"

module flag_writeback (
  input  logic                clk,
  input  logic                rst,
  input  alu_pkg::issue_t     issue,
  input  alu_pkg::adder_out_t add,
  input  alu_pkg::data_t      lm_result,
  input  logic                is_logic,
  input  logic                except,
  input  logic                except_thread,
  output alu_pkg::ret_t       ret
);

  logic                    is_sub;
  logic                    is_arith;
  logic [1:0]              wsel;   // 0:8 1:16 2:32 3:64
  logic [5:0]              msb;
  alu_pkg::data_t          mask;
  alu_pkg::data_t          res;
  logic                    carry;
  logic                    a_s;
  logic                    b_s;
  logic                    r_s;
  logic                    ovf;
  logic                    zero;
  logic                    par;
  logic [`ALU_FLAGS_W-1:0] flags_out;
  logic                    sets_flags;
  logic                    except_q;
  logic                    except_thread_q;
  logic                    inhibit;

  assign is_sub   = issue.op inside {`OP_SUB8, `OP_SUB16, `OP_SUB32, `OP_SUB64};
  assign is_arith = is_sub || issue.op inside {`OP_ADD8, `OP_ADD16, `OP_ADD32, `OP_ADD64};

  always_comb
  begin
    case (issue.op)
      `OP_ADD8, `OP_SUB8:   wsel = 2'd0;
      `OP_ADD16, `OP_SUB16: wsel = 2'd1;
      `OP_ADD32, `OP_SUB32, `OP_AND32, `OP_OR32, `OP_XOR32, `OP_XNOR32:
        wsel = 2'd2;
      default:              wsel = 2'd3;
    endcase
    case (wsel)
      2'd0:    {carry, msb} = {add.c8, 6'd7};
      2'd1:    {carry, msb} = {add.c16, 6'd15};
      2'd2:    {carry, msb} = {add.c32, 6'd31};
      default: {carry, msb} = {add.c64, 6'd63};
    endcase
  end

  assign res  = is_arith ? add.sum : lm_result;
  assign mask = {`ALU_DATA_W{1'b1}} >> (6'd63 - msb);
  assign a_s  = issue.a[msb];
  assign b_s  = issue.b[msb];
  assign r_s  = res[msb];
  assign zero = (res & mask) == '0;
  assign par  = ~^res[7:0];  // even parity of low byte

  // overflow when both effective operands agree in sign and the result does not
  assign ovf = (a_s ^ r_s) & ~(a_s ^ b_s ^ is_sub);

  always_comb
  begin
    sets_flags = 1'b1;
    if (is_arith)
      flags_out = {carry, ovf, add.c4, r_s, zero, par};
    else if (is_logic)
      flags_out = {3'b000, r_s, zero, par};
    else
    begin
      flags_out  = issue.flags_in;
      sets_flags = 1'b0;
    end
  end

  // except this cycle or last cycle on the same thread kills the return
  assign inhibit = (except && (except_thread == issue.thread)) ||
                   (except_q && (except_thread_q == issue.thread));

  always_ff @(posedge clk)
  begin
    ret.result <= res;
    ret.thread <= issue.thread;
    if (rst)
    begin
      ret.valid       <= 1'b0;
      ret.sets_flags  <= 1'b0;
      ret.flags       <= '0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end
    else
    begin
      ret.valid       <= issue.valid & ~inhibit;
      ret.sets_flags  <= sets_flags;
      ret.flags       <= flags_out;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

endmodule

// ==== alu_stage.sv ====
////////////////////////////////////////////////////////////
// Top of the one-stage integer execution unit. Takes one
// issue per clock and returns result and flags one cycle
// later; no back-pressure.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_stage (
  input  logic            clk,
  input  logic            rst,
  input  alu_pkg::issue_t issue,
  input  logic            except,
  input  logic            except_thread,
  output alu_pkg::ret_t   ret
);

  logic                taken;
  logic                is_logic;
  alu_pkg::adder_out_t add_out;
  alu_pkg::data_t      lm_result;

  cond_eval u_cond (
    .flags (issue.flags_in),
    .cond  (issue.cond),
    .taken (taken)
  );

  int_adder u_adder (
    .a   (issue.a),
    .b   (issue.b),
    .op  (issue.op),
    .out (add_out)
  );

  logic_move_unit u_lmu (
    .a        (issue.a),
    .b        (issue.b),
    .op       (issue.op),
    .taken    (taken),
    .result   (lm_result),
    .is_logic (is_logic)
  );

  flag_writeback u_wb (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .add           (add_out),
    .lm_result     (lm_result),
    .is_logic      (is_logic),
    .except        (except),
    .except_thread (except_thread),
    .ret           (ret)
  );

endmodule

// ==== tb_alu_model.svh ====
////////////////////////////////////////////////////////////
// Reference model and issue/check tasks for the execution
// unit testbench. Included inside the tb_alu module body.
////////////////////////////////////////////////////////////
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

function automatic alu_pkg::data_t width_mask(input int w);
  if (w >= 64)
    return '1;
  return (64'd1 << w) - 64'd1;
endfunction

function automatic int op_width(input alu_pkg::op_t op);
  case (op)
    `OP_ADD8, `OP_SUB8:   return 8;
    `OP_ADD16, `OP_SUB16: return 16;
    `OP_ADD32, `OP_SUB32, `OP_AND32, `OP_OR32, `OP_XOR32, `OP_XNOR32,
    `OP_MOV32:            return 32;
    default:              return 64;
  endcase
endfunction

// odd codes are the inverse of the even code below them
function automatic logic cond_taken(input alu_pkg::flags_t f, input alu_pkg::cond_t c);
  logic base;
  case (c[3:1])
    3'd0:    base = f.z;
    3'd1:    base = f.s;
    3'd2:    base = !f.c && !f.z; // unsigned above
    3'd3:    base = !f.c;
    3'd4:    base = (f.s == f.o) && !f.z;
    3'd5:    base = (f.s == f.o);
    3'd6:    base = f.o;
    default: base = f.p;
  endcase
  return base ^ c[0];
endfunction

function automatic alu_pkg::ret_t expected_ret(input alu_pkg::issue_t x, input logic inhibit);
  alu_pkg::ret_t  r;
  alu_pkg::data_t m;
  alu_pkg::data_t am;
  alu_pkg::data_t bm;
  alu_pkg::data_t res;
  logic [64:0]    wide;
  logic [4:0]     nib;
  logic           sub;
  logic           a_sign;
  logic           b_sign;
  logic           r_sign;
  int             w;
  w = op_width(x.op);
  m = width_mask(w);
  sub = x.op inside {`OP_SUB8, `OP_SUB16, `OP_SUB32, `OP_SUB64};
  r = '0;
  r.valid = x.valid & ~inhibit;
  r.thread = x.thread;
  r.flags = x.flags_in;
  case (x.op)
    `OP_ADD8, `OP_ADD16, `OP_ADD32, `OP_ADD64,
    `OP_SUB8, `OP_SUB16, `OP_SUB32, `OP_SUB64:
    begin
      am = x.a & m;
      bm = x.b & m;
      res = sub ? x.a - x.b : x.a + x.b;
      wide = {1'b0, am} + {1'b0, bm};
      nib = {1'b0, x.a[3:0]} + {1'b0, x.b[3:0]};
      a_sign = x.a[w-1];
      b_sign = x.b[w-1];
      r_sign = res[w-1];
      r.flags.c = sub ? (am < bm) : wide[w]; // borrow on subtract
      r.flags.o = sub ? (a_sign != b_sign && r_sign != a_sign)
                      : (a_sign == b_sign && r_sign != a_sign);
      r.flags.a = sub ? (x.a[3:0] < x.b[3:0]) : nib[4];
      r.sets_flags = 1'b1;
    end
    `OP_AND32, `OP_AND64,
    `OP_OR32, `OP_OR64,
    `OP_XOR32, `OP_XOR64,
    `OP_XNOR32, `OP_XNOR64:
    begin
      case (x.op)
        `OP_AND32, `OP_AND64: res = (x.a & x.b) & m;
        `OP_OR32, `OP_OR64:   res = (x.a | x.b) & m;
        `OP_XOR32, `OP_XOR64: res = (x.a ^ x.b) & m;
        default:              res = ~(x.a ^ x.b) & m;
      endcase
      r.flags = '0;
      r.sets_flags = 1'b1;
    end
    `OP_MOV32:    res = x.b & width_mask(32);
    `OP_MOV64:    res = x.b;
    `OP_ZXT8_64:  res = x.b & 64'hff;
    `OP_ZXT16_64: res = x.b & 64'hffff;
    `OP_SXT8_64:  res = x.b[7] ? (x.b | ~64'hff) : (x.b & 64'hff);
    `OP_SXT16_64: res = x.b[15] ? (x.b | ~64'hffff) : (x.b & 64'hffff);
    `OP_SXT32_64: res = x.b[31] ? (x.b | ~width_mask(32)) : (x.b & width_mask(32));
    `OP_CMOV64:   res = cond_taken(x.flags_in, x.cond) ? x.b : x.a;
    `OP_CSET:     res = cond_taken(x.flags_in, x.cond) ? 64'd1 : 64'd0;
    default:      res = '0;
  endcase
  if (r.sets_flags)
  begin
    r.flags.s = res[w-1];
    r.flags.z = (res & m) == '0;
    r.flags.p = ($countones(res[7:0]) % 2) == 0; // even count of ones in the low byte
  end
  r.result = res;
  return r;
endfunction

function automatic alu_pkg::data_t rand64();
  return {$urandom, $urandom};
endfunction

// cond, flags_in and thread are random
function automatic alu_pkg::issue_t make_issue(input alu_pkg::op_t op,
                                               input alu_pkg::data_t a,
                                               input alu_pkg::data_t b);
  alu_pkg::issue_t x;
  x.valid = 1'b1;
  x.thread = 1'($urandom);
  x.op = op;
  x.cond = 4'($urandom);
  x.a = a;
  x.b = b;
  x.flags_in = alu_pkg::flags_t'(6'($urandom));
  return x;
endfunction

task automatic drive(input alu_pkg::issue_t x, input logic exc, input logic exc_thr);
  @(posedge clk);
  issue <= x;
  except <= exc;
  except_thread <= exc_thr;
endtask

task automatic report_mismatch(input string name, input alu_pkg::data_t got,
                               input alu_pkg::data_t exp);
  errors++;
  $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
endtask

task automatic check_ret(input alu_pkg::ret_t exp);
  checks++;
  assert (ret.valid == exp.valid)
  else report_mismatch("ret.valid", 64'(ret.valid), 64'(exp.valid));
  if (exp.valid)
  begin
    assert (ret.thread == exp.thread)
    else report_mismatch("ret.thread", 64'(ret.thread), 64'(exp.thread));
    assert (ret.sets_flags == exp.sets_flags)
    else report_mismatch("ret.sets_flags", 64'(ret.sets_flags), 64'(exp.sets_flags));
    assert (ret.flags == exp.flags)
    else report_mismatch("ret.flags", {58'd0, ret.flags}, {58'd0, exp.flags});
    assert (ret.result == exp.result)
    else report_mismatch("ret.result", ret.result, exp.result);
  end
endtask

// one op then an idle cycle with the result checked after the sampling edge
task automatic run_op(input alu_pkg::issue_t x);
  drive(x, 1'b0, 1'b0);
  drive('0, 1'b0, 1'b0);
  @(negedge clk);
  check_ret(expected_ret(x, 1'b0));
endtask

`endif

// ==== tb_alu.sv ====
////////////////////////////////////////////////////////////
// Testbench for the integer execution unit. Runs directed
// tests for arithmetic, logic, moves, conditions, pipelining
// and thread inhibit, then prints an error summary.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_settings.svh"

module tb_alu;

  localparam int N_CORNER = 6;
  localparam int N_RAND   = 16;
  localparam int N_COND   = 4;
  localparam int N_B2B    = 24;
  localparam int TEST_CYCLES = 8 + 2 * (8 * (N_CORNER + N_RAND) + 15 * N_RAND + 32 * N_COND)
                               + N_B2B + 1 + 24;
  localparam int MARGIN   = 50;

  logic            clk;
  logic            rst;
  alu_pkg::issue_t issue;
  logic            except;
  logic            except_thread;
  alu_pkg::ret_t   ret;
  int              errors = 0;
  int              checks = 0;

  // 0..7 add/sub, 8..22 logic/move/ext, 23..24 cmov/cset
  alu_pkg::op_t all_ops [25] = '{
    `OP_ADD8, `OP_ADD16, `OP_ADD32, `OP_ADD64,
    `OP_SUB8, `OP_SUB16, `OP_SUB32, `OP_SUB64,
    `OP_AND32, `OP_AND64, `OP_OR32, `OP_OR64,
    `OP_XOR32, `OP_XOR64, `OP_XNOR32, `OP_XNOR64,
    `OP_MOV32, `OP_MOV64, `OP_ZXT8_64, `OP_ZXT16_64,
    `OP_SXT8_64, `OP_SXT16_64, `OP_SXT32_64,
    `OP_CMOV64, `OP_CSET
  };

  alu_stage dut (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .except        (except),
    .except_thread (except_thread),
    .ret           (ret)
  );

  always #10 clk = ~clk;

  `include "tb_alu_model.svh"

  task automatic reset_values();
    @(negedge clk);
    checks++;
    assert (ret.flags == '0)
    else report_mismatch("ret.flags", {58'd0, ret.flags}, 64'd0);
    repeat (4)
    begin
      assert (ret.valid == 1'b0)
      else report_mismatch("ret.valid", 64'(ret.valid), 64'd0);
      @(negedge clk);
    end
  endtask

  task automatic arith_ops();
    alu_pkg::data_t m;
    alu_pkg::data_t ca;
    alu_pkg::data_t cb;
    for (int i = 0; i < 8; i++)
    begin
      m = width_mask(op_width(all_ops[i]));
      for (int k = 0; k < N_CORNER + N_RAND; k++)
      begin
        ca = rand64();
        cb = rand64();
        case (k)
          0:
          begin
            ca = m >> 1; // largest positive
            cb = 64'd1;
          end
          1:
          begin
            ca = (m >> 1) + 64'd1; // most negative
            cb = 64'd1;
          end
          2:
          begin
            ca = m; // wraps to zero
            cb = 64'd1;
          end
          3: cb = ca;
          4:
          begin
            ca = 64'd0;
            cb = 64'd1;
          end
          5:
          begin
            ca = 64'h0f; // nibble carry
            cb = 64'h01;
          end
          default: ;
        endcase
        if (k < N_CORNER)
        begin
          ca = ca | (rand64() & ~m); // junk above the op width
          cb = cb | (rand64() & ~m);
        end
        run_op(make_issue(all_ops[i], ca, cb));
      end
    end
  endtask

  task automatic logic_move_ops();
    for (int i = 8; i < 23; i++)
      for (int k = 0; k < N_RAND; k++)
        run_op(make_issue(all_ops[i], rand64(), rand64()));
  endtask

  task automatic cond_ops();
    alu_pkg::issue_t x;
    for (int c = 0; c < 16; c++)
      for (int k = 0; k < N_COND; k++)
      begin
        x = make_issue(`OP_CMOV64, rand64(), rand64());
        x.cond = 4'(c);
        run_op(x);
        x.op = `OP_CSET;
        run_op(x);
      end
  endtask

  // a new op every cycle and each ret checked against the op before
  task automatic back_to_back();
    alu_pkg::issue_t x;
    alu_pkg::ret_t   expq[$];
    for (int i = 0; i < N_B2B; i++)
    begin
      x = make_issue(all_ops[$urandom_range(24, 0)], rand64(), rand64());
      expq.push_back(expected_ret(x, 1'b0));
      drive(x, 1'b0, 1'b0);
      if (i > 0)
      begin
        @(negedge clk);
        check_ret(expq.pop_front());
      end
    end
    drive('0, 1'b0, 1'b0);
    @(negedge clk);
    check_ret(expq.pop_front());
  endtask

  // gap is the number of cycles from the except to the op
  task automatic inhibit_case(input int gap, input logic same_thread);
    alu_pkg::issue_t x;
    logic            thr;
    x = make_issue(all_ops[$urandom_range(7, 0)], rand64(), rand64());
    thr = same_thread ? x.thread : ~x.thread;
    if (gap == 0)
      drive(x, 1'b1, thr);
    else
    begin
      drive('0, 1'b1, thr);
      repeat (gap - 1) drive('0, 1'b0, 1'b0);
      drive(x, 1'b0, 1'b0);
    end
    drive('0, 1'b0, 1'b0);
    @(negedge clk);
    check_ret(expected_ret(x, same_thread && gap < 2));
  endtask

  task automatic thread_inhibit();
    for (int gap = 0; gap < 3; gap++)
    begin
      inhibit_case(gap, 1'b1);
      inhibit_case(gap, 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(32'hd447));
    clk = 1'b0;
    rst = 1'b1;
    issue = '0;
    issue.valid = 1'b1; // pending op while reset is held
    except = 1'b0;
    except_thread = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    issue <= '0;
    reset_values();
    arith_ops();
    logic_move_ops();
    cond_ops();
    back_to_back();
    thread_inhibit();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // watchdog
  initial
  begin
    #((TEST_CYCLES + MARGIN) * 20);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
alu_pkg.sv
cond_eval.sv
int_adder.sv
logic_move_unit.sv
flag_writeback.sv
alu_stage.sv
tb_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_alu -o tb_alu
./obj_dir/tb_alu | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
